//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // what a port does in one cycle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } port_op_e;

  typedef enum logic {
    MAP_INIT = 1'b0, // identity sweep after reset
    MAP_RUN  = 1'b1
  } map_state_e;

endpackage

`default_nettype wire

//--- src/mem_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface bank_if #(
  parameter int WIDTH   = 16,
  parameter int NUMPBNK = 5,
  parameter int BITROW  = 4
);

  logic [NUMPBNK-1:0]             rd;
  logic [NUMPBNK-1:0]             wr;
  logic [NUMPBNK-1:0][BITROW-1:0] addr;
  logic [NUMPBNK-1:0][WIDTH-1:0]  din;
  logic [NUMPBNK-1:0][WIDTH-1:0]  dout; // registered bank output

  modport sched (output rd, wr, addr, din);
  modport bank  (input rd, wr, addr, din, output dout);
  modport mon   (input dout);

endinterface

interface map_if #(
  parameter int NUMVBNK = 4,
  parameter int BITROW  = 4,
  parameter int BITPBNK = 3
);

  logic [1:0][BITROW-1:0]               lk_row; // one lookup per port
  logic [1:0][NUMVBNK-1:0][BITPBNK-1:0] lk_map;
  logic                                 upd;
  logic [BITROW-1:0]                    upd_row;
  logic [NUMVBNK-1:0][BITPBNK-1:0]      upd_map;
  logic                                 ready;

  modport tbl (
    input  lk_row, upd, upd_row, upd_map,
    output lk_map, ready
  );

  modport sched (
    output lk_row, upd, upd_row, upd_map,
    input  lk_map, ready
  );

endinterface

`default_nettype wire

//--- src/bank_sram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_sram #(
  parameter  int WIDTH   = 16,
  parameter  int NUMVROW = 16,
  localparam int BITROW  = $clog2(NUMVROW)
) (
  input  logic              clk,
  input  logic              read,
  input  logic              write,
  input  logic [BITROW-1:0] addr,
  input  logic [WIDTH-1:0]  din,
  output logic [WIDTH-1:0]  dout
);

  logic [WIDTH-1:0] mem [NUMVROW];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= din;
    end
    if (read) begin
      dout <= mem[addr]; // holds until the next read
    end
  end

endmodule

`default_nettype wire

//--- src/remap_table.sv
`timescale 1ns/1ps
`default_nettype none

module remap_table
  import mem_pkg::*;
#(
  parameter  int NUMVBNK = 4,
  parameter  int NUMVROW = 16,
  localparam int BITROW  = $clog2(NUMVROW),
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int BITPBNK = $clog2(NUMPBNK)
) (
  input logic clk,
  input logic reset,
  map_if.tbl  map
);

  map_state_e                      state;
  logic [BITROW-1:0]               init_row;
  logic [NUMVBNK-1:0][BITPBNK-1:0] ident_map;
  logic [NUMVBNK-1:0][BITPBNK-1:0] row_map [NUMVROW];

  // logical bank i on physical bank i, physical bank NUMVBNK left spare
  always_comb begin
    for (int i = 0; i < NUMVBNK; i++) begin
      ident_map[i] = BITPBNK'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= MAP_INIT;
      init_row <= '0;
    end else if (state == MAP_INIT) begin
      init_row <= init_row + 1'b1;
      if (init_row == BITROW'(NUMVROW - 1)) begin
        state <= MAP_RUN;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == MAP_INIT) begin
      row_map[init_row] <= ident_map;
    end else if (map.upd) begin
      row_map[map.upd_row] <= map.upd_map; // redirected write
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      map.lk_map[p] = row_map[map.lk_row[p]];
    end
  end

  assign map.ready = (state == MAP_RUN);

endmodule

`default_nettype wire

//--- src/bank_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module bank_scheduler
  import mem_pkg::*;
#(
  parameter  int WIDTH   = 16,
  parameter  int NUMVBNK = 4,
  parameter  int NUMVROW = 16,
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITROW  = $clog2(NUMVROW),
  localparam int BITADDR = BITVBNK + BITROW,
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int BITPBNK = $clog2(NUMPBNK)
) (
  input  logic [1:0]              rw_read,
  input  logic [1:0]              rw_write,
  input  logic [2*BITADDR-1:0]    rw_addr,
  input  logic [2*WIDTH-1:0]      rw_din,
  map_if.sched                    map,
  bank_if.sched                   banks,
  output logic [1:0]              rd_accept,
  output logic [1:0][BITPBNK-1:0] rd_pbank,
  output logic                    rd_drop
);

  port_op_e                        op [2];
  port_op_e                        eop [2]; // after conflict resolution
  logic [BITADDR-1:0]              addr [2];
  logic [WIDTH-1:0]                din [2];
  logic [BITVBNK-1:0]              lbank [2];
  logic [BITROW-1:0]               row [2];
  logic [BITPBNK-1:0]              pbank [2];
  logic [BITPBNK-1:0]              tbank [2]; // bank actually strobed
  logic                            same_pbank;
  logic                            same_addr;
  logic                            kill0;
  logic                            redir;
  logic                            redir_port;
  logic [BITROW-1:0]               redir_row;
  logic [BITVBNK-1:0]              redir_lbank;
  logic [NUMVBNK-1:0][BITPBNK-1:0] redir_map;
  logic [NUMVBNK-1:0][BITPBNK-1:0] new_map;
  logic [BITPBNK-1:0]              free_bank;

  // the one physical bank that a row map does not use
  function automatic logic [BITPBNK-1:0] find_free(
    input logic [NUMVBNK-1:0][BITPBNK-1:0] row_map
  );
    logic [NUMPBNK-1:0] used;
    logic [BITPBNK-1:0] idx;
    used = '0;
    idx  = '0;
    for (int i = 0; i < NUMVBNK; i++) begin
      used[row_map[i]] = 1'b1;
    end
    for (int k = NUMPBNK - 1; k >= 0; k--) begin
      if (!used[k]) begin
        idx = BITPBNK'(k);
      end
    end
    return idx;
  endfunction

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      addr[p]  = rw_addr[p*BITADDR +: BITADDR];
      din[p]   = rw_din[p*WIDTH +: WIDTH];
      lbank[p] = addr[p][BITADDR-1:BITROW];
      row[p]   = addr[p][BITROW-1:0];
      if (!map.ready) begin
        op[p] = OP_IDLE;
      end else if (rw_write[p]) begin
        op[p] = OP_WRITE; // write wins over read on one port
      end else if (rw_read[p]) begin
        op[p] = OP_READ;
      end else begin
        op[p] = OP_IDLE;
      end
    end
  end

  assign map.lk_row[0] = row[0];
  assign map.lk_row[1] = row[1];

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      pbank[p] = map.lk_map[p][lbank[p]];
    end
  end

  always_comb begin
    same_pbank = (pbank[0] == pbank[1]);
    same_addr  = (addr[0] == addr[1]);
    rd_drop    = (op[0] == OP_READ) && (op[1] == OP_READ); // port 1 read is lost
    kill0      = (op[0] == OP_WRITE) && (op[1] == OP_WRITE) && same_addr;
    redir      = same_pbank && (op[0] != OP_IDLE) && (op[1] != OP_IDLE) &&
                 !rd_drop && !kill0;
    // only a write on port 0 facing a read on port 1 moves port 0
    redir_port = ((op[0] == OP_WRITE) && (op[1] == OP_READ)) ? 1'b0 : 1'b1;

    redir_row   = row[redir_port];
    redir_lbank = lbank[redir_port];
    redir_map   = map.lk_map[redir_port];
    free_bank   = find_free(redir_map);
    new_map     = redir_map;
    new_map[redir_lbank] = free_bank;

    eop[0] = kill0 ? OP_IDLE : op[0];
    eop[1] = rd_drop ? OP_IDLE : op[1];
    for (int p = 0; p < 2; p++) begin
      tbank[p] = (redir && (redir_port == 1'(p))) ? free_bank : pbank[p];
    end
  end

  assign map.upd     = redir;
  assign map.upd_row = redir_row;
  assign map.upd_map = new_map;

  // after resolution no two ports share a bank
  always_comb begin
    banks.rd = '0;
    banks.wr = '0;
    for (int b = 0; b < NUMPBNK; b++) begin
      banks.addr[b] = row[0];
      banks.din[b]  = din[0];
      for (int p = 0; p < 2; p++) begin
        if ((eop[p] != OP_IDLE) && (tbank[p] == BITPBNK'(b))) begin
          banks.rd[b]   = (eop[p] == OP_READ);
          banks.wr[b]   = (eop[p] == OP_WRITE);
          banks.addr[b] = row[p];
          banks.din[b]  = din[p];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_accept[p] = (eop[p] == OP_READ);
      rd_pbank[p]  = pbank[p]; // reads are never moved
    end
  end

endmodule

`default_nettype wire

//--- src/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return
  import mem_pkg::*;
#(
  parameter  int WIDTH   = 16,
  parameter  int NUMVBNK = 4,
  localparam int BITPBNK = $clog2(NUMVBNK + 1)
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [1:0]              rd_accept,
  input  logic [1:0][BITPBNK-1:0] rd_pbank,
  input  logic                    rd_drop,
  bank_if.mon                     banks,
  output logic [1:0]              rw_vld,
  output logic [1:0]              rw_serr,
  output logic [2*WIDTH-1:0]      rw_dout
);

  port_op_e                ret_op [2];
  logic                    drop_q;
  logic [1:0][BITPBNK-1:0] pbank_q;

  // lines up with the bank output register
  always_ff @(posedge clk) begin
    if (reset) begin
      ret_op[0] <= OP_IDLE;
      ret_op[1] <= OP_IDLE;
      drop_q    <= 1'b0;
    end else begin
      ret_op[0] <= rd_accept[0] ? OP_READ : OP_IDLE;
      ret_op[1] <= rd_accept[1] ? OP_READ : OP_IDLE;
      drop_q    <= rd_drop;
    end
  end

  always_ff @(posedge clk) begin
    pbank_q <= rd_pbank;
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rw_vld[p]                  = (ret_op[p] == OP_READ);
      rw_dout[p*WIDTH +: WIDTH]  = banks.dout[pbank_q[p]];
    end
  end

  assign rw_serr = {drop_q, 1'b0}; // port 0 reads are always served

endmodule

`default_nettype wire

//--- src/rw_2port_top.sv
`timescale 1ns/1ps
`default_nettype none

module rw_2port_top #(
  parameter  int WIDTH   = 16,
  parameter  int NUMVBNK = 4,
  parameter  int NUMVROW = 16,
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITROW  = $clog2(NUMVROW),
  localparam int BITADDR = BITVBNK + BITROW,
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int BITPBNK = $clog2(NUMPBNK)
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 ready,
  input  logic [1:0]           rw_read,
  input  logic [1:0]           rw_write,
  input  logic [2*BITADDR-1:0] rw_addr,
  input  logic [2*WIDTH-1:0]   rw_din,
  output logic [1:0]           rw_vld,
  output logic [1:0]           rw_serr,
  output logic [2*WIDTH-1:0]   rw_dout
);

  logic [1:0]              rd_accept;
  logic [1:0][BITPBNK-1:0] rd_pbank;
  logic                    rd_drop;

  bank_if #(
    .WIDTH   (WIDTH),
    .NUMPBNK (NUMPBNK),
    .BITROW  (BITROW)
  ) bank_bus ();

  map_if #(
    .NUMVBNK (NUMVBNK),
    .BITROW  (BITROW),
    .BITPBNK (BITPBNK)
  ) map_bus ();

  assign ready = map_bus.ready;

  remap_table #(
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) remap_table_inst (
    .clk   (clk),
    .reset (reset),
    .map   (map_bus.tbl)
  );

  bank_scheduler #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) bank_scheduler_inst (
    .rw_read   (rw_read),
    .rw_write  (rw_write),
    .rw_addr   (rw_addr),
    .rw_din    (rw_din),
    .map       (map_bus.sched),
    .banks     (bank_bus.sched),
    .rd_accept (rd_accept),
    .rd_pbank  (rd_pbank),
    .rd_drop   (rd_drop)
  );

  read_return #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK)
  ) read_return_inst (
    .clk       (clk),
    .reset     (reset),
    .rd_accept (rd_accept),
    .rd_pbank  (rd_pbank),
    .rd_drop   (rd_drop),
    .banks     (bank_bus.mon),
    .rw_vld    (rw_vld),
    .rw_serr   (rw_serr),
    .rw_dout   (rw_dout)
  );

  // NUMVBNK data banks plus the spare
  for (genvar i = 0; i < NUMPBNK; i++) begin : g_bank
    bank_sram #(
      .WIDTH   (WIDTH),
      .NUMVROW (NUMVROW)
    ) bank_sram_inst (
      .clk   (clk),
      .read  (bank_bus.rd[i]),
      .write (bank_bus.wr[i]),
      .addr  (bank_bus.addr[i]),
      .din   (bank_bus.din[i]),
      .dout  (bank_bus.dout[i])
    );
  end

endmodule

`default_nettype wire

//--- verif/tb_rw_2port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rw_2port;

  localparam int WIDTH   = 16;
  localparam int NUMVROW = 16;
  localparam int BITADDR = 6;
  localparam int MAX_VEC = 256;

  logic                 clk;
  logic                 reset;
  logic                 ready;
  logic [1:0]           rw_read;
  logic [1:0]           rw_write;
  logic [2*BITADDR-1:0] rw_addr;
  logic [2*WIDTH-1:0]   rw_din;
  logic [1:0]           rw_vld;
  logic [1:0]           rw_serr;
  logic [2*WIDTH-1:0]   rw_dout;

  int                   vec_test [MAX_VEC];
  logic [1:0]           vec_read [MAX_VEC];
  logic [1:0]           vec_write [MAX_VEC];
  logic [2*BITADDR-1:0] vec_addr [MAX_VEC];
  logic [2*WIDTH-1:0]   vec_din [MAX_VEC];
  logic [1:0]           exp_vld [MAX_VEC]; // result of the line before
  logic [1:0]           exp_serr [MAX_VEC];
  logic [2*WIDTH-1:0]   exp_dout [MAX_VEC];

  int num_vec      = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  rw_2port_top rw_2port_top_inst (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .rw_read  (rw_read),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_din   (rw_din),
    .rw_vld   (rw_vld),
    .rw_serr  (rw_serr),
    .rw_dout  (rw_dout)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      if (ready !== 1'b1) begin
        $display("timeout: ready never rose after reset");
      end else begin
        $display("timeout: vectors did not finish in %0d cycles", cycle_limit);
      end
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] t, r0, w0, a0, d0, r1, w1, a1, d1;
    logic [31:0] v0, s0, q0, v1, s1, q1;
    fd = $fopen("verif/rw_2port_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/rw_2port_testdata.txt");
      total_errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if ((n > 0) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      t, r0, w0, a0, d0, r1, w1, a1, d1, v0, s0, q0, v1, s1, q1);
          if ((n == 15) && (num_vec < MAX_VEC)) begin
            vec_test[num_vec]  = int'(t);
            vec_read[num_vec]  = {r1[0], r0[0]};
            vec_write[num_vec] = {w1[0], w0[0]};
            vec_addr[num_vec]  = {a1[BITADDR-1:0], a0[BITADDR-1:0]}; // port 0 in low bits
            vec_din[num_vec]   = {d1[WIDTH-1:0], d0[WIDTH-1:0]};
            exp_vld[num_vec]   = {v1[0], v0[0]};
            exp_serr[num_vec]  = {s1[0], s0[0]};
            exp_dout[num_vec]  = {q1[WIDTH-1:0], q0[WIDTH-1:0]};
            num_vec++;
          end else if (n > 0) begin
            $display("vector line could not be read: %s", line);
            total_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // no read results may show up here
  task automatic check_quiet();
    if (rw_vld !== 2'b00) begin
      $display("[ERROR] %0t rw_vld expected 00 got %b", $time, rw_vld);
      test_errors++;
    end
    if (rw_serr !== 2'b00) begin
      $display("[ERROR] %0t rw_serr expected 00 got %b", $time, rw_serr);
      test_errors++;
    end
  endtask

  task automatic check_outputs(input int k);
    if (rw_vld !== exp_vld[k]) begin
      $display("[ERROR] %0t rw_vld expected %b got %b", $time, exp_vld[k], rw_vld);
      test_errors++;
    end
    if (rw_serr !== exp_serr[k]) begin
      $display("[ERROR] %0t rw_serr expected %b got %b", $time, exp_serr[k], rw_serr);
      test_errors++;
    end
    for (int p = 0; p < 2; p++) begin
      if (exp_vld[k][p] && (rw_dout[p*WIDTH +: WIDTH] !== exp_dout[k][p*WIDTH +: WIDTH])) begin
        $display("[ERROR] %0t rw_dout[%0d] expected %h got %h", $time, p,
                 exp_dout[k][p*WIDTH +: WIDTH], rw_dout[p*WIDTH +: WIDTH]);
        test_errors++;
      end
    end
  endtask

  task automatic close_test(input int num);
    if (test_errors == 0) begin
      $display("test %0d passed", num);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    int wait_cycles;
    clk      = 1'b0;
    reset    = 1'b1;
    rw_read  = '0;
    rw_write = '0;
    rw_addr  = '0;
    rw_din   = '0;
    load_vectors();
    cycle_limit = NUMVROW + 2 * num_vec + 20;
    if (num_vec == 0) begin
      $display("no vectors were loaded");
      total_errors++;
    end

    repeat (3) begin
      @(posedge clk);
      #1;
      if (ready !== 1'b0) begin
        $display("[ERROR] %0t ready expected 0 got %b", $time, ready);
        test_errors++;
      end
      check_quiet();
    end
    reset = 1'b0;

    wait_cycles = 0;
    while (ready !== 1'b1) begin
      @(posedge clk);
      #1;
      wait_cycles++;
      check_quiet();
    end
    if (wait_cycles > NUMVROW + 2) begin
      $display("ready rose %0d cycles after reset, later than allowed", wait_cycles);
      test_errors++;
    end

    // one vector per cycle at 1 ns after the rising edge
    for (int k = 0; k < num_vec; k++) begin
      if ((k > 0) && (vec_test[k] != vec_test[k-1])) begin
        close_test(vec_test[k-1]);
      end
      rw_read  = vec_read[k];
      rw_write = vec_write[k];
      rw_addr  = vec_addr[k];
      rw_din   = vec_din[k];
      @(negedge clk);
      check_outputs(k);
      @(posedge clk);
      #1;
    end
    if (num_vec > 0) begin
      close_test(vec_test[num_vec-1]);
    end
    rw_read  = '0;
    rw_write = '0;

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, total_errors + test_errors);
    if ((total_errors == 0) && (test_errors == 0) && (tests_failed == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/mem_pkg.sv
src/mem_ifs.sv
src/bank_sram.sv
src/remap_table.sv
src/bank_scheduler.sv
src/read_return.sv
src/rw_2port_top.sv
verif/tb_rw_2port.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_rw_2port \
  -o tb_rw_2port > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_rw_2port > sim.log 2>&1 \
  || { cat sim.log; echo "simulation did not run to the end"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log \
  && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }

//--- verif/rw_2port_testdata.txt
# test r0 w0 addr0 din0 r1 w1 addr1 din1 exp_vld0 exp_serr0 exp_dout0 exp_vld1 exp_serr1 exp_dout1
# hex except test; addr = {logical bank, row}; expected columns hold the result of the line before
# test 1: idle after ready
1 0 0 00 0000 0 0 00 0000 0 0 0000 0 0 0000
1 0 0 00 0000 0 0 00 0000 0 0 0000 0 0 0000
# test 2: single writes read back from either port
2 0 1 05 1111 0 0 00 0000 0 0 0000 0 0 0000
2 0 0 00 0000 0 1 23 2222 0 0 0000 0 0 0000
2 0 0 00 0000 1 0 05 0000 0 0 0000 0 0 0000
2 1 0 23 0000 0 0 00 0000 0 0 0000 1 0 1111
2 0 0 00 0000 0 0 00 0000 1 0 2222 0 0 0000
# test 3: two writes into one logical bank, repeated redirections
3 0 1 10 3000 0 1 11 3001 0 0 0000 0 0 0000
3 0 1 12 3002 0 1 13 3003 0 0 0000 0 0 0000
3 0 1 13 3013 0 1 11 3111 0 0 0000 0 0 0000
3 0 1 10 3010 0 1 11 3211 0 0 0000 0 0 0000
3 0 1 24 3024 0 0 00 0000 0 0 0000 0 0 0000
3 1 0 10 0000 0 0 00 0000 0 0 0000 0 0 0000
3 0 0 00 0000 1 0 11 0000 1 0 3010 0 0 0000
3 1 0 12 0000 0 0 00 0000 0 0 0000 1 0 3211
3 0 0 00 0000 1 0 13 0000 1 0 3002 0 0 0000
3 1 0 24 0000 0 0 00 0000 0 0 0000 1 0 3013
3 0 0 00 0000 0 0 00 0000 1 0 3024 0 0 0000
# test 4: read and write on one bank, old value first, also at one address
4 1 0 10 0000 0 1 15 4015 0 0 0000 0 0 0000
4 0 0 00 0000 1 0 15 0000 1 0 3010 0 0 0000
4 0 1 10 4010 1 0 12 0000 0 0 0000 1 0 4015
4 1 0 10 0000 0 0 00 0000 0 0 0000 1 0 3002
4 0 1 24 4024 1 0 24 0000 1 0 4010 0 0 0000
4 1 0 24 0000 0 0 00 0000 0 0 0000 1 0 3024
4 1 0 15 0000 0 1 15 5015 1 0 4024 0 0 0000
4 0 0 00 0000 1 0 15 0000 1 0 4015 0 0 0000
4 0 0 00 0000 0 0 00 0000 0 0 0000 1 0 5015
# test 5: two writes to one address keep port 1 data
5 0 1 36 6000 0 1 36 6001 0 0 0000 0 0 0000
5 0 1 11 6011 0 1 11 6111 0 0 0000 0 0 0000
5 1 0 36 0000 0 0 00 0000 0 0 0000 0 0 0000
5 0 0 00 0000 1 0 11 0000 1 0 6001 0 0 0000
5 0 0 00 0000 0 0 00 0000 0 0 0000 1 0 6111
# test 6: two reads flag port 1, then back to back reads
6 1 0 05 0000 1 0 23 0000 0 0 0000 0 0 0000
6 1 0 10 0000 1 0 10 0000 1 0 1111 0 1 0000
6 0 0 00 0000 0 0 00 0000 1 0 4010 0 1 0000
6 1 0 12 0000 0 0 00 0000 0 0 0000 0 0 0000
6 0 0 00 0000 1 0 13 0000 1 0 3002 0 0 0000
6 1 0 24 0000 0 0 00 0000 0 0 0000 1 0 3013
6 0 0 00 0000 1 0 36 0000 1 0 4024 0 0 0000
6 1 0 11 0000 0 0 00 0000 0 0 0000 1 0 6001
6 0 0 00 0000 0 0 00 0000 1 0 6111 0 0 0000
